// ==== nrvInput.txt ====
# Columns, all hex: instruction word, expected wbEn, wbId, value, nextPc
# Program order from PC 0, words as fetched after branches and jumps
123450B7 1 01 12345000 00000004
00001117 1 02 00001004 00000008
FFB00193 1 03 FFFFFFFB 0000000C
00700213 1 04 00000007 00000010
403202B3 1 05 0000000C 00000014
4011D313 1 06 FFFFFFFD 00000018
0011D393 1 07 7FFFFFFD 0000001C
0041A433 1 08 00000001 00000020
0041B4B3 1 09 00000000 00000024
00520013 1 00 0000000C 00000028
00400533 1 0A 00000007 0000002C
0041C5B3 1 0B FFFFFFFC 00000030
0080066F 1 0C 00000034 00000038
010606E7 1 0D 0000003C 00000044
00A20663 0 00 00000000 00000050
00A21463 0 00 00000000 00000054
0041E463 0 00 00000000 00000058
00325863 0 00 00000000 00000068
00102823 0 00 00000000 0000006C
00300AA3 0 00 00000000 00000070
00B01D23 0 00 00000000 00000074
01002703 1 0E 12345000 00000078
01500783 1 0F FFFFFFFB 0000007C
01504803 1 10 000000FB 00000080
01A01883 1 11 FFFFFFFC 00000084
01A05903 1 12 0000FFFC 00000088
00421A13 1 14 00000070 0000008C

// ==== flist.f ====
nrvPkg.sv
nrvDecoder.sv
nrvRegFile.sv
nrvAlu.sv
nrvDataRam.sv
nrvExecCore.sv
nrvExecCore_asserts.sv
nrvTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the nrvTb simulation with Verilator
log=sim.log

verilator --binary --timing --assert --top-module nrvTb -f flist.f -o nrvSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/nrvSim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Errors found" "$log"; then
   echo "Simulation reported failures"
   exit 1
fi
echo "Simulation passed"
exit 0

// ==== nrvTb.sv ====
// Testbench for the RV32I execution core
// Reads instruction words and expected retire fields from nrvInput.txt
// Drives one instruction per strobe, random idle gaps, checks each retire

`timescale 1ns/1ns

module nrvTb;
   import nrvPkg::*;

   logic        clk;
   logic        rst;
   instrInT     instrIn;
   retireT      retire;
   int          errors;
   int          checks;
   int          fd;
   int          fields;
   int          maxWait;       // Cycles allowed for a retire
   integer      seed;
   string       line;
   logic [31:0] word;
   logic [31:0] expWbEn;
   logic [31:0] expWbId;
   logic [31:0] expValue;
   logic [31:0] expNextPc;
   logic        retired;
   logic        timedOut;

   nrvExecCore nrvExecCore_i (
      .clk     (clk),
      .rst     (rst),
      .instrIn (instrIn),
      .retire  (retire)
   );

   bind nrvExecCore nrvExecCoreAsserts nrvExecCoreAsserts_i (
      .clk     (clk),
      .rst     (rst),
      .instrIn (instrIn),
      .retire  (retire)
   );

   always #10 clk = ~clk;      // 20 ns period

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   // Strobe is held across one edge only and the retire is then awaited
   task automatic waitRetire(output logic seen);
      int n;
      seen = 1'b0;
      n = 0;
      while (!seen && n < maxWait) begin
         @(posedge clk);
         #2;
         instrIn.strobe = 1'b0;
         seen = retire.strobe;   // Stable 2 ns after the edge
         n++;
      end
   endtask

   initial begin
      errors   = 0;
      checks   = 0;
      maxWait  = 10;
      seed     = 17693;
      timedOut = 1'b0;
      clk      = 1'b0;
      rst      = 1'b1;
      instrIn  = '0;

      // Strobe during reset must neither retire nor write back
      instrIn.strobe = 1'b1;
      instrIn.instr  = 32'h0010_0093; // ADDI x1, x0, 1
      repeat (3) @(posedge clk);
      #2;
      instrIn.strobe = 1'b0;          // Low again before the last reset edge
      @(posedge clk);
      #2;
      rst = 1'b0;
      checkValue("retire.strobe", 32'(retire.strobe), 32'd0);
      checkValue("retire.wbEn", 32'(retire.wbEn), 32'd0);

      fd = $fopen("nrvInput.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file nrvInput.txt");
         errors++;
      end else begin
         while (!timedOut && $fgets(line, fd) != 0) begin
            fields = $sscanf(line, "%h %h %h %h %h",
                             word, expWbEn, expWbId, expValue, expNextPc);
            if (line.getc(0) != "#" && fields == 5) begin
               if (($random(seed) & 1) != 0) begin
                  @(posedge clk);                // Idle cycle with strobe low
                  #2;
               end
               instrIn.strobe = 1'b1;
               instrIn.instr  = word;
               waitRetire(retired);
               if (!retired) begin
                  $display("Timeout: instruction %h never retired", word);
                  errors++;
                  timedOut = 1'b1;
               end else begin
                  checkValue("retire.wbEn", 32'(retire.wbEn), expWbEn);
                  if (expWbEn != 0) begin         // Payload only meaningful with write-back
                     checkValue("retire.wbId", 32'(retire.wbId), expWbId);
                     checkValue("retire.value", retire.value, expValue);
                  end
                  checkValue("retire.nextPc", retire.nextPc, expNextPc);
               end
            end
         end
         $fclose(fd);
      end

      $display("Checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// ==== nrvExecCore_asserts.sv ====
// Concurrent checks on the core's strobe and retire timing
// Bound into nrvExecCore from the testbench

`timescale 1ns/1ns

module nrvExecCoreAsserts
   import nrvPkg::*;
(
   input logic    clk,
   input logic    rst,
   input instrInT instrIn,
   input retireT  retire
);

   // Each accepted strobe retires on the next cycle
   strobeRetires: assert property (@(posedge clk) disable iff (rst)
      instrIn.strobe |=> retire.strobe)
      else $error("Instruction strobe not followed by a retire strobe");

   // A retire only ever follows a strobe one cycle earlier
   noRetireWithoutStrobe: assert property (@(posedge clk) disable iff (rst)
      retire.strobe |-> $past(instrIn.strobe))
      else $error("Retire strobe without a preceding instruction strobe");

   // Quiet retire port while in reset and on the first cycle after
   quietAfterReset: assert property (@(posedge clk)
      rst |=> (!retire.strobe && !retire.wbEn))
      else $error("Retire active during or right after reset");

endmodule

// ==== nrvExecCore.sv ====
// Single-issue RV32I execution core
// PC register, operand and write-back muxes, next PC selection
// Retire register, one cycle after each instruction strobe

`timescale 1ns/1ns

module nrvExecCore
   import nrvPkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  instrInT instrIn,
   output retireT  retire
);

   decodeT      dec;
   logic [31:0] pc;
   logic [31:0] pcPlus4;
   logic [31:0] branchTarget;  // Separate PC + imm adder
   logic [31:0] nextPc;
   logic [31:0] rs1Data;
   logic [31:0] rs2Data;
   logic [31:0] opA;
   logic [31:0] opB;
   logic [31:0] aluResult;
   logic [31:0] aluSum;
   logic        branchTaken;
   logic [31:0] loadData;
   logic [31:0] wbValue;
   logic        regWrEn;

   nrvDecoder nrvDecoder_i (
      .instr (instrIn.instr),
      .dec   (dec)
   );

   assign regWrEn = instrIn.strobe & dec.wbEn;

   nrvRegFile nrvRegFile_i (
      .clk     (clk),
      .rst     (rst),
      .rdId1   (dec.rs1Id),
      .rdId2   (dec.rs2Id),
      .wrEn    (regWrEn),
      .wrId    (dec.wbId),
      .wrData  (wbValue),
      .rdData1 (rs1Data),
      .rdData2 (rs2Data)
   );

   assign opA = dec.aluInSel1 ? pc : rs1Data;
   assign opB = dec.aluInSel2 ? dec.imm : rs2Data;

   nrvAlu nrvAlu_i (
      .opA         (opA),
      .opB         (opB),
      .func        (dec.func),
      .funcQual    (dec.funcQual & dec.isAlu), // Only register/imm ops subtract
      .result      (aluResult),
      .sum         (aluSum),
      .branchTaken (branchTaken)
   );

   nrvDataRam nrvDataRam_i (
      .clk    (clk),
      .wrEn   (instrIn.strobe & dec.isStore),
      .addr   (aluSum[DataAddrBits+1:0]),
      .func   (dec.func),
      .wrData (rs2Data),
      .rdData (loadData)
   );

   assign pcPlus4      = pc + 32'd4;
   assign branchTarget = pc + dec.imm;

   always_comb begin
      case (dec.wbSrc)
         wbAlu:     wbValue = aluResult;
         wbPcPlus4: wbValue = pcPlus4;
         wbAplusB:  wbValue = aluSum;
         default:   wbValue = loadData;
      endcase
   end

   // Jump beats taken branch beats fall-through
   always_comb begin
      if (dec.isJump) nextPc = {aluSum[31:1], 1'b0};
      else if (dec.isBranch && branchTaken) nextPc = branchTarget;
      else nextPc = pcPlus4;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc            <= ResetPc;
         retire.strobe <= 1'b0;
         retire.wbEn   <= 1'b0;
      end else begin
         retire.strobe <= instrIn.strobe;
         retire.wbEn   <= regWrEn;
         if (instrIn.strobe) begin
            pc             <= nextPc;
            retire.wbId    <= dec.wbId;   // Payload held between strobes
            retire.value   <= wbValue;
            retire.nextPc  <= nextPc;
         end
      end
   end

endmodule

// ==== nrvDataRam.sv ====
// Data RAM, word organized
// Byte, halfword and word stores through byte enables
// Combinational load with sign or zero extension

`timescale 1ns/1ns

module nrvDataRam
   import nrvPkg::*;
(
   input  logic                    clk,
   input  logic                    wrEn,
   input  logic [DataAddrBits+1:0] addr,   // Byte address
   input  logic [2:0]              func,   // Size in [1:0], unsigned in [2]
   input  logic [31:0]             wrData,
   output logic [31:0]             rdData
);

   logic [31:0]             mem [DataWords];
   logic [DataAddrBits-1:0] wordAddr;
   logic [3:0]              byteEn;
   logic [31:0]             wrLanes;   // Store data replicated on all lanes
   logic [31:0]             word;
   logic [7:0]              rdByte;
   logic [15:0]             rdHalf;

   assign wordAddr = addr[DataAddrBits+1:2];

   always_comb begin
      case (func[1:0])
         2'b00: begin
            byteEn  = 4'b0001 << addr[1:0];
            wrLanes = {4{wrData[7:0]}};
         end
         2'b01: begin
            byteEn  = addr[1] ? 4'b1100 : 4'b0011;
            wrLanes = {2{wrData[15:0]}};
         end
         default: begin
            byteEn  = 4'b1111;
            wrLanes = wrData;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      for (int b = 0; b < 4; b++) begin
         if (wrEn && byteEn[b]) mem[wordAddr][8*b +: 8] <= wrLanes[8*b +: 8];
      end
   end

   assign word   = mem[wordAddr];
   assign rdByte = word[8*addr[1:0] +: 8];
   assign rdHalf = addr[1] ? word[31:16] : word[15:0];

   always_comb begin
      case (func[1:0])
         2'b00:   rdData = {{24{rdByte[7] & !func[2]}}, rdByte};  // LB / LBU
         2'b01:   rdData = {{16{rdHalf[15] & !func[2]}}, rdHalf}; // LH / LHU
         default: rdData = word;
      endcase
   end

endmodule

// ==== nrvAlu.sv ====
// Integer ALU for RV32I
// Adder, logic ops, shifts and set-less-than
// Branch predicate from func on the two operands

`timescale 1ns/1ns

module nrvAlu
   import nrvPkg::*;
(
   input  logic [31:0] opA,
   input  logic [31:0] opB,
   input  logic [2:0]  func,
   input  logic        funcQual,
   output logic [31:0] result,
   output logic [31:0] sum,
   output logic        branchTaken
);

   aluOpE       op;
   logic [4:0]  shamt;
   logic [31:0] diff;
   logic        eq;
   logic        lt;   // Signed compare
   logic        ltu;  // Unsigned compare

   assign op    = aluOpE'(func);
   assign shamt = opB[4:0];
   assign sum   = opA + opB;         // LUI, AUIPC, jumps and addresses
   assign diff  = opA - opB;
   assign eq    = (opA == opB);
   assign lt    = $signed(opA) < $signed(opB);
   assign ltu   = opA < opB;

   always_comb begin
      case (op)
         aluAdd:  result = funcQual ? diff : sum;
         aluSll:  result = opA << shamt;
         aluSlt:  result = {31'd0, lt};
         aluSltu: result = {31'd0, ltu};
         aluXor:  result = opA ^ opB;
         aluSr: begin
            if (funcQual) begin
               result = $unsigned($signed(opA) >>> shamt); // SRA keeps the sign
            end else begin
               result = opA >> shamt;
            end
         end
         aluOr:   result = opA | opB;
         aluAnd:  result = opA & opB;
         default: result = sum;
      endcase
   end

   // Branch tests, func values 010 and 011 are unused
   always_comb begin
      case (func)
         3'b000:  branchTaken = eq;     // BEQ
         3'b001:  branchTaken = !eq;    // BNE
         3'b100:  branchTaken = lt;     // BLT
         3'b101:  branchTaken = !lt;    // BGE
         3'b110:  branchTaken = ltu;    // BLTU
         3'b111:  branchTaken = !ltu;   // BGEU
         default: branchTaken = 1'b0;
      endcase
   end

endmodule

// ==== nrvRegFile.sv ====
// Integer register file, 32 x 32 bits
// Two combinational reads, one synchronous write, x0 reads zero

`timescale 1ns/1ns

module nrvRegFile (
   input  logic        clk,
   input  logic        rst,
   input  logic [4:0]  rdId1,
   input  logic [4:0]  rdId2,
   input  logic        wrEn,
   input  logic [4:0]  wrId,
   input  logic [31:0] wrData,
   output logic [31:0] rdData1,
   output logic [31:0] rdData2
);

   logic [31:0] regs [31:1]; // No storage behind x0

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn && (wrId != 5'd0)) begin
         regs[wrId] <= wrData;           // Writes to x0 dropped
      end
   end

   // Reads see the old value until the write edge
   assign rdData1 = (rdId1 == 5'd0) ? 32'd0 : regs[rdId1];
   assign rdData2 = (rdId2 == 5'd0) ? 32'd0 : regs[rdId2];

endmodule

// ==== nrvDecoder.sv ====
// RV32I instruction decoder
// Fixed-position fields, the five immediate formats
// and per-opcode control signals, no error checking

`timescale 1ns/1ns

module nrvDecoder
   import nrvPkg::*;
(
   input  logic [31:0] instr,
   output decodeT      dec
);

   opcodeE      opcode;
   logic [2:0]  func;
   logic        funcIsShift;
   logic [31:0] iImm;
   logic [31:0] sImm;
   logic [31:0] bImm;
   logic [31:0] jImm;
   logic [31:0] uImm;

   assign opcode = opcodeE'(instr[6:2]); // Low two bits ignored
   assign func   = instr[14:12];

   // Immediates, all sign extended from bit 31
   assign iImm = {{21{instr[31]}}, instr[30:20]};
   assign sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
   assign uImm = {instr[31:12], 12'h000};

   // SLLI, SRLI and SRAI carry a qualifier in bit 30
   assign funcIsShift = (func == 3'b001) || (func == 3'b101);

   always_comb begin
      dec = '0;                       // Unknown opcode: no write-back, no jump
      dec.wbId  = instr[11:7];
      dec.rs1Id = instr[19:15];
      dec.rs2Id = instr[24:20];
      dec.func  = func;
      dec.wbSrc = wbAlu;

      case (opcode)
         opLui: begin
            dec.wbEn      = 1'b1;
            dec.wbSrc     = wbAplusB;  // x0 + U imm through the adder
            dec.rs1Id     = 5'd0;
            dec.aluInSel2 = 1'b1;
            dec.imm       = uImm;
         end
         opAuipc: begin
            dec.wbEn      = 1'b1;
            dec.wbSrc     = wbAplusB;
            dec.aluInSel1 = 1'b1;      // PC + U imm
            dec.aluInSel2 = 1'b1;
            dec.imm       = uImm;
         end
         opJal: begin
            dec.wbEn      = 1'b1;
            dec.wbSrc     = wbPcPlus4; // Link register
            dec.aluInSel1 = 1'b1;      // Target = PC + J imm
            dec.aluInSel2 = 1'b1;
            dec.isJump    = 1'b1;
            dec.imm       = jImm;
         end
         opJalr: begin
            dec.wbEn      = 1'b1;
            dec.wbSrc     = wbPcPlus4;
            dec.aluInSel2 = 1'b1;      // Target = rs1 + I imm
            dec.isJump    = 1'b1;
            dec.imm       = iImm;
         end
         opBranch: begin
            // Compare is rs1 against rs2, target adder lives in the core
            dec.isBranch = 1'b1;
            dec.imm      = bImm;
         end
         opAluImm: begin
            dec.wbEn      = 1'b1;
            dec.aluInSel2 = 1'b1;
            dec.funcQual  = funcIsShift ? instr[30] : 1'b0; // SRLI or SRAI
            dec.isAlu     = 1'b1;
            dec.imm       = iImm;
         end
         opAluReg: begin
            dec.wbEn     = 1'b1;
            dec.funcQual = instr[30]; // ADD/SUB, SRL/SRA
            dec.isAlu    = 1'b1;
         end
         opLoad: begin
            dec.wbEn      = 1'b1;
            dec.wbSrc     = wbLoad;
            dec.aluInSel2 = 1'b1;      // Address = rs1 + I imm
            dec.isLoad    = 1'b1;
            dec.imm       = iImm;
         end
         opStore: begin
            dec.aluInSel2 = 1'b1;      // Address = rs1 + S imm
            dec.isStore   = 1'b1;
            dec.imm       = sImm;
         end
         default: begin
            // Treated as a no-op
         end
      endcase
   end

endmodule

// ==== nrvPkg.sv ====
// Shared types and constants for the RV32I execution core
// Opcode and ALU operation enums, write-back source enum
// Decode, instruction input and retire structs
// Data RAM sizing and reset PC

package nrvPkg;

   // Data RAM geometry
   localparam int DataWords = 256;      // Words in the data RAM
   localparam int DataAddrBits = 8;     // Word address width
   localparam logic [31:0] ResetPc = 32'h0000_0000;

   // Major opcodes, instr[6:2] (bits 1:0 are always 11)
   typedef enum logic [4:0] {
      opLoad   = 5'b00000,
      opAluImm = 5'b00100,
      opAuipc  = 5'b00101,
      opStore  = 5'b01000,
      opAluReg = 5'b01100,
      opLui    = 5'b01101,
      opBranch = 5'b11000,
      opJalr   = 5'b11001,
      opJal    = 5'b11011
   } opcodeE;

   // ALU operations, same encoding as func (instr[14:12])
   typedef enum logic [2:0] {
      aluAdd  = 3'b000,                 // ADD or SUB by funcQual
      aluSll  = 3'b001,
      aluSlt  = 3'b010,
      aluSltu = 3'b011,
      aluXor  = 3'b100,
      aluSr   = 3'b101,                 // SRL or SRA by funcQual
      aluOr   = 3'b110,
      aluAnd  = 3'b111
   } aluOpE;

   // Source of the register write-back value
   typedef enum logic [1:0] {
      wbAlu     = 2'd0,
      wbPcPlus4 = 2'd1,
      wbAplusB  = 2'd2,
      wbLoad    = 2'd3
   } wbSrcE;

   typedef struct packed {
      logic        wbEn;                // Register write-back enable
      logic [4:0]  wbId;                // Destination register
      wbSrcE       wbSrc;
      logic [4:0]  rs1Id;               // Forced to zero for LUI
      logic [4:0]  rs2Id;
      logic        aluInSel1;           // 0 reg, 1 PC
      logic        aluInSel2;           // 0 reg, 1 imm
      logic [2:0]  func;                // ALU op, branch test or load/store size
      logic        funcQual;            // SUB and SRA qualifier
      logic        isAlu;
      logic        isLoad;
      logic        isStore;
      logic        isBranch;
      logic        isJump;
      logic [31:0] imm;                 // Selected immediate
   } decodeT;

   typedef struct packed {
      logic        strobe;              // One cycle per instruction
      logic [31:0] instr;
   } instrInT;

   typedef struct packed {
      logic        strobe;
      logic        wbEn;
      logic [4:0]  wbId;
      logic [31:0] value;               // Write-back value
      logic [31:0] nextPc;
   } retireT;

endpackage
